//--- compile.f
+incdir+rtl
+incdir+tb
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/control_decode.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/rf.sv
rtl/hart.sv
tb/tb_hart.sv

//--- rtl/alu.sv
module alu (
    input  isa_pkg::alu_op_e i_op,
    input  isa_pkg::word_t   i_a,
    input  isa_pkg::word_t   i_b,
    output isa_pkg::word_t   o_result,
    output logic             o_eq,
    output logic             o_lt
);

    import isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits of the operand give the shift distance
    assign shamt = i_b[4:0];

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    ////////////////////
    // compare flags
    ////////////////////

    // branches read these, beq and bne use only the eq flag
    assign o_eq = (i_a == i_b);

    // sltu selects the unsigned compare, every other op reports signed
    assign o_lt = (i_op == alu_sltu) ? lt_unsigned : lt_signed;

    ////////////////////
    // result
    ////////////////////

    always_comb begin
        case (i_op)
            alu_add: begin
                o_result = i_a + i_b;
            end
            alu_sub: begin
                o_result = i_a - i_b;
            end
            alu_sll: begin
                o_result = i_a << shamt;
            end
            alu_slt: begin
                o_result = word_t'(lt_signed);
            end
            alu_sltu: begin
                o_result = word_t'(lt_unsigned);
            end
            alu_xor: begin
                o_result = i_a ^ i_b;
            end
            alu_srl: begin
                o_result = i_a >> shamt;
            end
            alu_sra: begin
                // arithmetic shift fills with the sign of the first operand
                o_result = word_t'($signed(i_a) >>> shamt);
            end
            alu_or: begin
                o_result = i_a | i_b;
            end
            alu_and: begin
                o_result = i_a & i_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- rtl/bus_pkg.sv
package bus_pkg;

    import isa_pkg::*;

    // data memory request, the address is always word aligned
    // and at most one of the two strobes is high in a cycle
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  ren;
        logic  wen;
    } dmem_req_t;

    // record of the instruction that finishes this cycle
    typedef struct packed {
        logic      valid;
        logic      halt;
        word_t     inst;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        reg_addr_t rd_waddr;
        word_t     rd_wdata;
        word_t     pc;
        word_t     next_pc;
    } retire_t;

endpackage

//--- rtl/control_decode.sv
module control_decode (
    input  isa_pkg::word_t   i_inst,
    output isa_pkg::ctrl_t   o_ctrl,
    output isa_pkg::funct3_t o_branch_cond
);

    import isa_pkg::*;

    opcode_e opcode;
    funct3_t funct3;
    // bit 30 separates sub from add and sra from srl
    logic    alt;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign alt    = i_inst[30];

    // the hart evaluates the condition itself from the alu flags
    assign o_branch_cond = funct3;

    ////////////////////
    // alu operation from funct3 and funct7
    ////////////////////

    // sub only exists in the register form, addi ignores bit 30
    function automatic alu_op_e arith_op(input funct3_t f3, input logic alt_bit,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt_bit) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt_bit ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    ////////////////////
    // control flags per opcode
    ////////////////////

    always_comb begin
        // anything not matched below retires as a no-op
        o_ctrl = '0;
        case (opcode)
            opc_op: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.uses_rs1  = 1'b1;
                o_ctrl.uses_rs2  = 1'b1;
                o_ctrl.alu_op    = arith_op(funct3, alt, 1'b1);
            end
            opc_op_imm: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.uses_rs1    = 1'b1;
                o_ctrl.alu_op      = arith_op(funct3, alt, 1'b0);
            end
            opc_load: begin
                // address is rs1 plus offset, the alu_op stays add
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.uses_rs1    = 1'b1;
            end
            opc_store: begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.uses_rs1    = 1'b1;
                o_ctrl.uses_rs2    = 1'b1;
            end
            opc_branch: begin
                // beq and bne only need the eq flag so any compare op is fine
                o_ctrl.branch   = 1'b1;
                o_ctrl.uses_rs1 = 1'b1;
                o_ctrl.uses_rs2 = 1'b1;
                o_ctrl.alu_op   = (funct3[2:1] == 2'b11) ? alu_sltu : alu_slt;
            end
            opc_lui: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.lui       = 1'b1;
            end
            opc_jal: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.jump      = 1'b1;
            end
            opc_system: begin
                // every other system encoding falls back to a no-op
                o_ctrl.halt = (i_inst == ebreak_inst);
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- rtl/hart.sv
`include "hart_params.svh"

module hart #(
    parameter isa_pkg::word_t RESET_ADDR = `HART_RESET_ADDR
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    output isa_pkg::word_t     o_imem_raddr,
    input  isa_pkg::word_t     i_imem_rdata,
    output bus_pkg::dmem_req_t o_dmem,
    input  isa_pkg::word_t     i_dmem_rdata,
    output bus_pkg::retire_t   o_retire
);

    import isa_pkg::*;
    import bus_pkg::*;

    word_t     pc;
    word_t     pc_plus4;
    word_t     next_pc;
    logic      halted;
    // high while the hart is out of reset and has not hit ebreak
    logic      active;

    ctrl_t     ctrl;
    funct3_t   branch_cond;
    word_t     imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_eq;
    logic      alu_lt;
    logic      cond_met;
    logic      taken;
    word_t     wb_data;

    assign active   = i_rst_n && !halted;
    assign rs1_addr = i_imem_rdata[19:15];
    assign rs2_addr = i_imem_rdata[24:20];
    assign rd_addr  = i_imem_rdata[11:7];

    ////////////////////
    // pc and halt state
    ////////////////////

    // once ebreak retires the pc stays on it and nothing else retires
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc     <= RESET_ADDR;
            halted <= 1'b0;
        end else if (active) begin
            if (ctrl.halt) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

    assign o_imem_raddr = pc;

    ////////////////////
    // decode, register file and alu
    ////////////////////

    control_decode u_control_decode (
        .i_inst       (i_imem_rdata),
        .o_ctrl       (ctrl),
        .o_branch_cond(branch_cond)
    );

    imm_gen u_imm_gen (
        .i_inst(i_imem_rdata),
        .o_imm (imm)
    );

    // the register write is dropped while halted or in reset
    rf u_rf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_raddr(rs1_addr),
        .i_rs2_raddr(rs2_addr),
        .o_rs1_rdata(rs1_data),
        .o_rs2_rdata(rs2_data),
        .i_rd_wen   (active && ctrl.reg_write),
        .i_rd_waddr (rd_addr),
        .i_rd_wdata (wb_data)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .i_op    (ctrl.alu_op),
        .i_a     (rs1_data),
        .i_b     (alu_b),
        .o_result(alu_result),
        .o_eq    (alu_eq),
        .o_lt    (alu_lt)
    );

    ////////////////////
    // branch and next pc
    ////////////////////

    // signed or unsigned lt was already chosen by the decoder through alu_op
    always_comb begin
        case (branch_cond)
            f3_beq:          cond_met = alu_eq;
            f3_bne:          cond_met = !alu_eq;
            f3_blt, f3_bltu: cond_met = alu_lt;
            f3_bge, f3_bgeu: cond_met = !alu_lt;
            default:         cond_met = 1'b0;
        endcase
    end

    assign taken    = ctrl.branch && cond_met;
    assign pc_plus4 = pc + `PC_STEP;
    assign next_pc  = (ctrl.jump || taken) ? (pc + imm) : pc_plus4;

    // writeback priority: load data, link address, upper immediate, alu
    assign wb_data = ctrl.mem_to_reg ? i_dmem_rdata :
                     ctrl.jump       ? pc_plus4     :
                     ctrl.lui        ? imm          : alu_result;

    ////////////////////
    // data memory and retire
    ////////////////////

    // only word accesses exist so the low two address bits are dropped
    assign o_dmem.addr  = {alu_result[`XLEN-1:2], 2'b00};
    assign o_dmem.wdata = rs2_data;
    assign o_dmem.ren   = active && ctrl.mem_read;
    assign o_dmem.wen   = active && ctrl.mem_write;

    assign o_retire.valid     = active;
    assign o_retire.halt      = active && ctrl.halt;
    assign o_retire.inst      = i_imem_rdata;
    // unused source registers report x0 and therefore zero data
    assign o_retire.rs1_raddr = ctrl.uses_rs1 ? rs1_addr : '0;
    assign o_retire.rs2_raddr = ctrl.uses_rs2 ? rs2_addr : '0;
    assign o_retire.rs1_rdata = (o_retire.rs1_raddr == '0) ? '0 : rs1_data;
    assign o_retire.rs2_rdata = (o_retire.rs2_raddr == '0) ? '0 : rs2_data;
    assign o_retire.rd_waddr  = ctrl.reg_write ? rd_addr : '0;
    assign o_retire.rd_wdata  = ctrl.reg_write ? wb_data : '0;
    assign o_retire.pc        = pc;
    assign o_retire.next_pc   = next_pc;

    // decoder flags and the halt gating together keep the strobes exclusive
    a_dmem_strobes_excl: assert property (
        @(posedge i_clk) !(o_dmem.ren && o_dmem.wen)
    );

    // immediates from the decoder must keep every pc update on a word boundary
    a_pc_word_aligned: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) pc[1:0] == 2'b00
    );

endmodule

//--- rtl/hart_params.svh
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// pc value loaded while reset is held, where the first fetch happens
`define HART_RESET_ADDR 32'h0000_0000

// width of the datapath, the registers and both memory addresses
`define XLEN 32

// number of architectural integer registers, x0 included
`define NUM_REGS 32

// byte distance between two consecutive instruction words
`define PC_STEP 4

`endif

//--- rtl/imm_gen.sv
module imm_gen (
    input  isa_pkg::word_t i_inst,
    output isa_pkg::word_t o_imm
);

    import isa_pkg::*;

    opcode_e opcode;
    // bit 31 is the sign of every immediate format
    logic    sign;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign sign   = i_inst[31];

    always_comb begin
        case (opcode)
            // i format, shifts also land here and the alu keeps the low five bits
            opc_op_imm, opc_load: begin
                o_imm = {{20{sign}}, i_inst[31:20]};
            end
            // s format splits the offset around rd
            opc_store: begin
                o_imm = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
            end
            // b format, offsets are in half words so bit 0 is implied zero
            opc_branch: begin
                o_imm = {{19{sign}}, sign, i_inst[7], i_inst[30:25],
                         i_inst[11:8], 1'b0};
            end
            // u format places the 20 bits at the top
            opc_lui: begin
                o_imm = {i_inst[31:12], 12'b0};
            end
            // j format with its scrambled bit order
            opc_jal: begin
                o_imm = {{11{sign}}, sign, i_inst[19:12], i_inst[20],
                         i_inst[30:21], 1'b0};
            end
            // r format, system and unknown opcodes carry no immediate
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

//--- rtl/isa_pkg.sv
`include "hart_params.svh"

package isa_pkg;

    // basic word carried through the datapath and on the memory ports
    typedef logic [`XLEN-1:0] word_t;

    // index into the register file
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

    // funct3 field, bits 14:12 of every format that has one
    typedef logic [2:0] funct3_t;

    // major opcodes of the supported subset, all others decode as no-ops
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    // alu operations, add is zero so a cleared control word means add
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // branch conditions as encoded in funct3
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // the only system instruction recognised, it stops the hart
    localparam word_t ebreak_inst = 32'h0010_0073;

    // decoded controls for one instruction
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    branch;
        logic    jump;
        logic    lui;
        logic    halt;
        logic    uses_rs1;
        logic    uses_rs2;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- rtl/rf.sv
`include "hart_params.svh"

module rf (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  isa_pkg::reg_addr_t i_rs1_raddr,
    input  isa_pkg::reg_addr_t i_rs2_raddr,
    output isa_pkg::word_t     o_rs1_rdata,
    output isa_pkg::word_t     o_rs2_rdata,
    input  logic               i_rd_wen,
    input  isa_pkg::reg_addr_t i_rd_waddr,
    input  isa_pkg::word_t     i_rd_wdata
);

    import isa_pkg::*;

    // entry 0 is cleared with the rest and never written afterwards
    word_t regs [`NUM_REGS];

    // write lands at the edge, a read in the same cycle still sees the old value
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    // x0 reads are forced to zero regardless of the array contents
    assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 : regs[i_rs1_raddr];
    assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 : regs[i_rs2_raddr];

    // the stored x0 entry keeps its reset value whatever the write port is given
    a_x0_stays_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        regs[0] == '0
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the hart testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_hart -f compile.f -o tb_hart_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_hart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

exit 0

//--- tb/hart_model.svh
`ifndef HART_MODEL_SVH
`define HART_MODEL_SVH

// reference state of the hart, kept apart from the DUT
word_t m_regs [32];
word_t m_dmem [256];
word_t m_pc;
logic  m_first;

// alu result as the base ISA defines it, indexed by funct3 and the alternate bit
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// run one instruction on the model and compare every retire field
task automatic model_step(input retire_t r);
    word_t      inst;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      wb;
    word_t      nxt;
    word_t      addr;
    logic [2:0] f3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       wr;
    logic       u1;
    logic       u2;
    logic       ld;
    logic       st;
    logic       hlt;
    logic       tk;
    int         beh;
    inst  = prog[m_pc[9:2]];
    f3    = inst[14:12];
    rs1   = inst[19:15];
    rs2   = inst[24:20];
    rd    = inst[11:7];
    a     = m_regs[rs1];
    b     = m_regs[rs2];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    {wr, u1, u2, ld, st, hlt} = '0;
    wb    = '0;
    addr  = '0;
    nxt   = m_pc + 4;
    beh   = 2;
    case (inst[6:0])
        7'h33: begin
            {wr, u1, u2} = 3'b111;
            wb = alu_ref(f3, inst[30], a, b);
        end
        7'h13: begin
            {wr, u1} = 2'b11;
            wb = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
        end
        7'h03: begin
            {wr, u1, ld} = 3'b111;
            addr = (a + imm_i) & ~32'h3;
            wb   = m_dmem[addr[9:2]];
            beh  = 3;
        end
        7'h23: begin
            {u1, u2, st} = 3'b111;
            addr = (a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) & ~32'h3;
            beh  = 3;
        end
        7'h63: begin
            {u1, u2} = 2'b11;
            case (f3)
                3'd0: tk = (a == b);
                3'd1: tk = (a != b);
                3'd4: tk = $signed(a) < $signed(b);
                3'd5: tk = $signed(a) >= $signed(b);
                3'd6: tk = a < b;
                default: tk = a >= b;
            endcase
            if (tk) begin
                nxt = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            beh = 4;
        end
        7'h37: begin
            wr = 1'b1;
            wb = {inst[31:12], 12'b0};
        end
        7'h6f: begin
            wr  = 1'b1;
            wb  = m_pc + 4;
            nxt = m_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            beh = 4;
        end
        default: begin
            hlt = (inst == 32'h0010_0073);
            beh = 6;
        end
    endcase
    // a write aimed at x0 belongs to the x0 behavior
    if (wr && rd == 5'd0) begin
        beh = 5;
    end
    if (m_first) begin
        check_value(1, "retire.pc (first)", `HART_RESET_ADDR, r.pc);
        m_first = 1'b0;
    end
    check_value(beh, "retire.pc", m_pc, r.pc);
    check_value(beh, "imem_raddr", m_pc, o_imem_raddr);
    check_value(beh, "retire.inst", inst, r.inst);
    check_value(beh, "retire.halt", hlt, r.halt);
    check_value(beh, "retire.rs1_raddr", u1 ? rs1 : 5'd0, r.rs1_raddr);
    check_value(beh, "retire.rs2_raddr", u2 ? rs2 : 5'd0, r.rs2_raddr);
    check_value(beh, "retire.rs1_rdata", u1 ? a : 32'd0, r.rs1_rdata);
    check_value(beh, "retire.rs2_rdata", u2 ? b : 32'd0, r.rs2_rdata);
    check_value(beh, "retire.rd_waddr", wr ? rd : 5'd0, r.rd_waddr);
    check_value(beh, "retire.rd_wdata", wb, r.rd_wdata);
    check_value(beh, "retire.next_pc", nxt, r.next_pc);
    check_value(beh, "dmem.ren", ld, o_dmem.ren);
    check_value(beh, "dmem.wen", st, o_dmem.wen);
    if (ld || st) begin
        check_value(3, "dmem.addr", addr, o_dmem.addr);
    end
    if (st) begin
        check_value(3, "dmem.wdata", b, o_dmem.wdata);
        m_dmem[addr[9:2]] = b;
    end
    if (wr && rd != 5'd0) begin
        m_regs[rd] = wb;
    end
    if (hlt) begin
        halt_seen = 1'b1;
    end else begin
        m_pc = nxt;
    end
endtask

`endif

//--- tb/tb_hart.sv
`include "hart_params.svh"

module tb_hart;

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import bus_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 4;
    localparam int PROG_LEN   = 200;

    logic      i_clk;
    logic      i_rst_n;
    word_t     o_imem_raddr;
    word_t     i_imem_rdata;
    dmem_req_t o_dmem;
    word_t     i_dmem_rdata;
    retire_t   o_retire;

    word_t       prog [256];
    word_t       dmem [256];
    logic [31:0] lfsr = 32'h98cd_6efd;
    logic        halt_seen = 1'b0;
    int          checks [1:6];
    int          fails [1:6];
    string       beh_name [1:6];

    hart u_hart (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_imem_raddr(o_imem_raddr),
        .i_imem_rdata(i_imem_rdata),
        .o_dmem      (o_dmem),
        .i_dmem_rdata(i_dmem_rdata),
        .o_retire    (o_retire)
    );

    // one mismatch line per failing comparison, counted under its behavior
    task automatic check_value(input int beh, input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks[beh]++;
        if (act !== exp) begin
            fails[beh]++;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    `include "hart_model.svh"

    // fibonacci lfsr with taps 32 22 2 1, one step for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    ////////////////////
    // program builder
    ////////////////////

    // every control transfer goes forward so the run always reaches ebreak
    task automatic build_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [20:0] off;
        int          span;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = 3'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            rd   = 5'(rand_bits(5));
            rs1  = 5'(rand_bits(5));
            rs2  = 5'(rand_bits(5));
            span = (PROG_LEN - 1 - i < 8) ? PROG_LEN - 1 - i : 8;
            off  = 21'((1 + rand_bits(8) % span) * 4);
            case (kind)
                3'd0, 3'd1: begin
                    imm = {1'b0, 1'(rand_bits(1)) & (f3 == 3'd0 || f3 == 3'd5), 10'b0};
                    prog[i] = {imm[11:5], rs2, rs1, f3, rd, 7'h33};
                end
                3'd2, 3'd3: begin
                    imm = 12'(rand_bits(12));
                    // shifts only accept the shift amount and the sra bit
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = {1'b0, imm[10] & (f3 == 3'd5), 5'b0};
                    end
                    prog[i] = {imm, rs1, f3, rd, 7'h13};
                end
                3'd4: begin
                    prog[i] = {20'(rand_bits(20)), rd, 7'h37};
                end
                3'd5: begin
                    // x0 base and a small positive offset stay inside the data array
                    imm = {2'b0, 10'(rand_bits(10))};
                    if (rand_bits(1)) begin
                        prog[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
                    end else begin
                        prog[i] = {imm, 5'd0, 3'b010, rd, 7'h03};
                    end
                end
                3'd6: begin
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = f3 - 3'd2;
                    end
                    prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
                end
                default: begin
                    prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
                end
            endcase
        end
        for (int i = PROG_LEN - 1; i < 256; i++) begin
            prog[i] = 32'h0010_0073;
        end
    endtask

    ////////////////////
    // clock, memories and watchdog
    ////////////////////

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    // fetch data follows the new pc, load data follows the decoded address
    initial begin
        forever begin
            @(posedge i_clk);
            #1 i_imem_rdata = prog[o_imem_raddr[9:2]];
            #1 i_dmem_rdata = dmem[o_dmem.addr[9:2]];
        end
    end

    always @(posedge i_clk) begin
        if (o_dmem.wen) begin
            dmem[o_dmem.addr[9:2]] <= o_dmem.wdata;
        end
    end

    // the program retires at most once per word, the limit leaves ample margin
    initial begin
        #((RST_CYCLES + 400) * CLK_PERIOD);
        $display("timeout: the hart did not halt within 400 cycles after reset");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////
    // checker, sampled at the falling edge
    ////////////////////

    initial begin
        forever begin
            @(negedge i_clk);
            if (!i_rst_n) begin
                check_value(1, "retire.valid (reset)", 0, o_retire.valid);
                check_value(1, "dmem.ren (reset)", 0, o_dmem.ren);
                check_value(1, "dmem.wen (reset)", 0, o_dmem.wen);
                check_value(1, "imem_raddr (reset)", `HART_RESET_ADDR, o_imem_raddr);
            end else begin
                check_value(3, "dmem.ren&wen", 0, o_dmem.ren && o_dmem.wen);
                if (halt_seen) begin
                    // the pc stays on the ebreak that stopped the hart
                    check_value(6, "retire.valid (halted)", 0, o_retire.valid);
                    check_value(6, "dmem.ren (halted)", 0, o_dmem.ren);
                    check_value(6, "dmem.wen (halted)", 0, o_dmem.wen);
                    check_value(6, "imem_raddr (halted)", m_pc, o_imem_raddr);
                end else if (o_retire.valid) begin
                    model_step(o_retire);
                end else begin
                    checks[6]++;
                    fails[6]++;
                    $display("t=%0t the hart stopped retiring before any ebreak", $time);
                end
            end
        end
    end

    initial begin
        int total_checks;
        int total_fails;
        beh_name[1] = "reset and first fetch";
        beh_name[2] = "alu and lui results";
        beh_name[3] = "word loads and stores";
        beh_name[4] = "branches and jal";
        beh_name[5] = "x0 stays zero";
        beh_name[6] = "ebreak halt";
        for (int k = 1; k <= 6; k++) begin
            checks[k] = 0;
            fails[k]  = 0;
        end
        i_rst_n      = 1'b0;
        i_dmem_rdata = '0;
        build_program();
        i_imem_rdata = prog[0];
        for (int k = 0; k < 256; k++) begin
            // fill value depends on every address bit
            dmem[k]   = 32'h5a3c_0000 ^ (k * 32'h9e37_79b1);
            m_dmem[k] = dmem[k];
        end
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = '0;
        end
        m_pc    = `HART_RESET_ADDR;
        m_first = 1'b1;
        repeat (RST_CYCLES) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        wait (halt_seen);
        repeat (20) @(negedge i_clk);
        total_checks = 0;
        total_fails  = 0;
        for (int k = 1; k <= 6; k++) begin
            $display("behavior %0d %s: %0d checks, %0d failed", k, beh_name[k], checks[k],
                     fails[k]);
            total_checks += checks[k];
            total_fails  += fails[k];
        end
        $display("total: %0d checks, %0d failed", total_checks, total_fails);
        if (total_fails == 0 && total_checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
